// ==== sim.f ====
schedPkg.sv
dispatchDecode.sv
issueQueue.sv
wakeupLogic.sv
selectIssue.sv
schedulerTop.sv
scheduler_properties.sv
schedulerTb.sv

// ==== Makefile ====
TOP = schedulerTb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -o simv
	./obj_dir/simv

lint:
	verilator --lint-only -Wall --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== schedulerTb.sv ====
/*
 * Scheduler testbench
 * Random and directed dispatch with stall and flush pulses, checked against
 * a scoreboard of entry class, source dependencies and divider spacing.
 */
`timescale 1ns/1ps

module schedulerTb;

    localparam int NUM_CYCLES = 340;
    localparam int DRAIN_START = 290;

    logic clk = 1'b0;
    logic rst;
    logic write;
    logic [schedPkg::ENTRY_BITS-1:0] writePtr;
    schedPkg::opTypeT opType;
    logic subType;
    logic srcValidA;
    logic [schedPkg::TAG_BITS-1:0] srcTagA;
    logic srcValidB;
    logic [schedPkg::TAG_BITS-1:0] srcTagB;
    logic dstValid;
    logic [schedPkg::TAG_BITS-1:0] dstTag;
    logic stall;
    logic [schedPkg::ENTRY_NUM-1:0] flushEntry;
    logic [schedPkg::PIPE_NUM-1:0] issueValid;
    logic [schedPkg::ENTRY_BITS-1:0] issuePtr0;
    logic [schedPkg::ENTRY_BITS-1:0] issuePtr1;
    logic [schedPkg::ENTRY_BITS-1:0] issuePtr2;
    logic [schedPkg::ENTRY_BITS-1:0] issuePtr3;
    logic [schedPkg::ENTRY_NUM-1:0] notIssued;

    // Scoreboard per entry, filled at dispatch
    int entryPipe [schedPkg::ENTRY_NUM];
    bit entryDiv [schedPkg::ENTRY_NUM];
    bit waitA [schedPkg::ENTRY_NUM];
    bit waitB [schedPkg::ENTRY_NUM];
    logic [schedPkg::TAG_BITS-1:0] tagA [schedPkg::ENTRY_NUM];
    logic [schedPkg::TAG_BITS-1:0] tagB [schedPkg::ENTRY_NUM];
    bit dstV [schedPkg::ENTRY_NUM];
    logic [schedPkg::TAG_BITS-1:0] dstT [schedPkg::ENTRY_NUM];
    int dispCycle [schedPkg::ENTRY_NUM];
    int wakeCycle [schedPkg::ENTRY_NUM];
    // Mirror of the ready table, set while a producer has not issued
    bit tagPending [schedPkg::PHY_REG_NUM];

    logic [schedPkg::ENTRY_NUM-1:0] expNot;
    logic [schedPkg::ENTRY_NUM-1:0] flushPrev;
    bit stallPrev;
    int wrOld;
    int wrLast;
    int cyc;
    int lastDiv;
    int busyIssues;
    int nextTag;
    bit lastDstValid;
    logic [schedPkg::TAG_BITS-1:0] lastDst;
    int seed = 28785;

    schedulerTop DUT (.*);

    always #5 clk = ~clk;

    function automatic int randBelow(input int n);
        return int'({$random(seed)} % n);
    endfunction

    function automatic int pickEntry(input logic [schedPkg::ENTRY_NUM-1:0] mask);
        int start;
        int idx;
        start = randBelow(schedPkg::ENTRY_NUM);
        for (int k = 0; k < schedPkg::ENTRY_NUM; k++) begin
            idx = (start + k) % schedPkg::ENTRY_NUM;
            if (mask[idx]) return idx;
        end
        return 0;
    endfunction

    task automatic expectEq(input string test, input int exp, input int act);
        assert (exp == act) else begin
            $display("ERROR %s: expected %0d, actual %0d", test, exp, act);
            $display("FAIL: see errors above");
            $fatal(1, "%s mismatch", test);
        end
    endtask

    task automatic checkIssue(input int p, input int e);
        expectEq("issue of an occupied entry", 1, int'(expNot[e] && !flushPrev[e]));
        expectEq("pipe routing", entryPipe[e], p);
        if (cyc - dispCycle[e] < 2) expectEq("dispatch to issue latency", 2, cyc - dispCycle[e]);
        expectEq("sources woken before issue", 0, int'(waitA[e] || waitB[e]));
        if (wakeCycle[e] >= cyc) expectEq("producer issue cycle", cyc - 1, wakeCycle[e]);
        if (entryDiv[e]) begin
            if (cyc - lastDiv < schedPkg::DIV_LATENCY) begin
                expectEq("div spacing", schedPkg::DIV_LATENCY, cyc - lastDiv);
            end
            lastDiv = cyc;
        end else if (p == schedPkg::PIPE_COMPLEX && cyc - lastDiv < schedPkg::DIV_LATENCY) begin
            // Non-div complex op slipping past a busy divider
            busyIssues++;
        end
        if (dstV[e]) begin
            tagPending[dstT[e]] = 1'b0;
            // Consumers waiting on this tag are woken by the broadcast
            for (int j = 0; j < schedPkg::ENTRY_NUM; j++) begin
                if (waitA[j] && tagA[j] == dstT[e]) begin
                    waitA[j] = 1'b0;
                    wakeCycle[j] = cyc;
                end
                if (waitB[j] && tagB[j] == dstT[e]) begin
                    waitB[j] = 1'b0;
                    wakeCycle[j] = cyc;
                end
            end
        end
    endtask

    task automatic checkOutputs();
        int ptr [schedPkg::PIPE_NUM];
        logic [schedPkg::ENTRY_NUM-1:0] issuedMask;
        ptr[0] = int'(issuePtr0);
        ptr[1] = int'(issuePtr1);
        ptr[2] = int'(issuePtr2);
        ptr[3] = int'(issuePtr3);
        issuedMask = '0;
        if (stallPrev) expectEq("stall holds issue", 0, int'(issueValid));
        for (int p = 0; p < schedPkg::PIPE_NUM; p++) begin
            if (issueValid[p]) begin
                checkIssue(p, ptr[p]);
                issuedMask[ptr[p]] = 1'b1;
            end
        end
        // A dispatch lands in the queue two edges after it is driven
        if (wrOld >= 0) expNot[wrOld] = 1'b1;
        expNot = expNot & ~issuedMask & ~flushPrev;
        expectEq("notIssued", int'(expNot), int'(notIssued));
        wrOld = wrLast;
        wrLast = -1;
    endtask

    task automatic driveInputs();
        logic [schedPkg::ENTRY_NUM-1:0] freeMask;
        int e;
        int kind;
        int mode;
        int t;
        write = 1'b0;
        stall = 1'b0;
        flushEntry = '0;
        if (cyc >= DRAIN_START) return;
        // Random ops, then div bursts, then dependency chains
        mode = (cyc < 120) ? 0 : (cyc < 200) ? 1 : 2;
        stall = (randBelow(8) == 0);
        if (randBelow(20) == 0 && notIssued != '0) flushEntry[pickEntry(notIssued)] = 1'b1;
        freeMask = ~notIssued;
        if (wrOld >= 0) freeMask[wrOld] = 1'b0;
        if (freeMask == '0 || randBelow(4) == 0) return;
        e = pickEntry(freeMask);
        kind = (mode == 0) ? randBelow(4) : (mode == 1) ? 1 : randBelow(2);
        subType = (kind == 3) || (kind == 1 && mode != 2 && randBelow(2) == 0);
        opType = (kind == 0) ? schedPkg::OP_INT :
                 (kind == 1) ? schedPkg::OP_COMPLEX : schedPkg::OP_MEM;
        srcValidA = (mode == 2) ? lastDstValid : (mode == 0 && randBelow(2) == 0);
        srcTagA = (mode == 2) ? lastDst : schedPkg::TAG_BITS'(randBelow(schedPkg::PHY_REG_NUM));
        srcValidB = (mode == 0 && randBelow(4) == 0);
        srcTagB = schedPkg::TAG_BITS'(randBelow(schedPkg::PHY_REG_NUM));
        dstValid = 1'b0;
        for (int k = 0; k < schedPkg::PHY_REG_NUM; k++) begin
            t = (nextTag + k) % schedPkg::PHY_REG_NUM;
            if (kind != 3 && !dstValid && !tagPending[t]) begin
                dstValid = 1'b1;
                dstTag = schedPkg::TAG_BITS'(t);
                nextTag = t + 1;
            end
        end
        write = 1'b1;
        writePtr = schedPkg::ENTRY_BITS'(e);
        entryPipe[e] = kind;
        entryDiv[e] = (kind == 1) && subType;
        waitA[e] = srcValidA && tagPending[srcTagA];
        waitB[e] = srcValidB && tagPending[srcTagB];
        tagA[e] = srcTagA;
        tagB[e] = srcTagB;
        dstV[e] = dstValid;
        dstT[e] = dstTag;
        wakeCycle[e] = -1;
        dispCycle[e] = cyc + 1;
        if (dstValid) tagPending[dstTag] = 1'b1;
        lastDstValid = dstValid;
        lastDst = dstTag;
        wrLast = e;
    endtask

    initial begin
        rst = 1'b1;
        write = 1'b0;
        writePtr = '0;
        opType = schedPkg::OP_INT;
        subType = 1'b0;
        srcValidA = 1'b0;
        srcTagA = '0;
        srcValidB = 1'b0;
        srcTagB = '0;
        dstValid = 1'b0;
        dstTag = '0;
        stall = 1'b0;
        flushEntry = '0;
        expNot = '0;
        flushPrev = '0;
        stallPrev = 1'b0;
        wrOld = -1;
        wrLast = -1;
        cyc = 0;
        lastDiv = -100;
        busyIssues = 0;
        nextTag = 0;
        lastDstValid = 1'b0;
        lastDst = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        repeat (NUM_CYCLES) begin
            @(negedge clk);
            cyc++;
            checkOutputs();
            driveInputs();
            stallPrev = stall;
            flushPrev = flushEntry;
        end
        if (busyIssues > 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("ERROR complex issue while divider busy: expected at least 1, actual %0d",
                     busyIssues);
            $display("FAIL: see errors above");
            $fatal(1, "non-div complex ops held by the divider");
        end
    end

    // Run length is reset plus NUM_CYCLES, well inside this bound
    initial begin
        #((400 * 10) + 500);
        $display("Simulation timed out before all tests finished");
        $display("FAIL: see errors above");
        $fatal(1, "timeout");
    end

endmodule

// ==== scheduler_properties.sv ====
/*
 * Scheduler properties
 * Stall, flush, reset, dispatch occupancy and minimum issue latency checks.
 */
`timescale 1ns/1ps

module schedulerProperties (
    input logic                            clk,
    input logic                            rst,
    input logic                            stall,
    input logic [schedPkg::ENTRY_NUM-1:0]  flushEntry,
    input logic                            dispWrite,
    input logic [schedPkg::ENTRY_BITS-1:0] dispPtr,
    input logic [schedPkg::PIPE_NUM-1:0]   issueValid,
    input logic [schedPkg::ENTRY_BITS-1:0] issuePtr0,
    input logic [schedPkg::ENTRY_BITS-1:0] issuePtr1,
    input logic [schedPkg::ENTRY_BITS-1:0] issuePtr2,
    input logic [schedPkg::ENTRY_BITS-1:0] issuePtr3,
    input logic [schedPkg::ENTRY_NUM-1:0]  notIssued
);

    logic [schedPkg::ENTRY_NUM-1:0] dispMask;
    logic [schedPkg::ENTRY_NUM-1:0] dispMaskQ;
    logic [schedPkg::PIPE_NUM-1:0][schedPkg::ENTRY_BITS-1:0] issuePtr;

    assign dispMask = dispWrite ? (schedPkg::ENTRY_NUM'(1) << dispPtr) : '0;
    assign issuePtr = {issuePtr3, issuePtr2, issuePtr1, issuePtr0};

    always_ff @(posedge clk) begin
        dispMaskQ <= dispMask;
    end

    stallBlocksIssue: assert property (@(posedge clk) disable iff (rst)
        stall |=> issueValid == '0)
        else $error("issue seen one cycle after a stall");

    stallHoldsQueue: assert property (@(posedge clk) disable iff (rst)
        stall |=> notIssued == (($past(notIssued) | $past(dispMask)) & ~$past(flushEntry)))
        else $error("queue occupancy changed during a stall");

    flushClears: assert property (@(posedge clk) disable iff (rst)
        (flushEntry != '0) |=> (notIssued & $past(flushEntry)) == '0)
        else $error("flushed entry still marked not issued");

    resetClears: assert property (@(posedge clk)
        rst |=> (issueValid == '0) && (notIssued == '0))
        else $error("issue or occupancy left set after reset");

    dispatchIntoFree: assert property (@(posedge clk) disable iff (rst)
        dispWrite |-> !notIssued[dispPtr])
        else $error("dispatch into an occupied entry");

    // An entry dispatched in the last two cycles is too young to issue
    for (genvar p = 0; p < schedPkg::PIPE_NUM; p++) begin : gLatency
        minLatency: assert property (@(posedge clk) disable iff (rst)
            issueValid[p] |-> !dispMask[issuePtr[p]] && !dispMaskQ[issuePtr[p]])
            else $error("pipe %0d issued an entry dispatched under two cycles ago", p);
    end

endmodule

bind schedulerTop schedulerProperties props (
    .clk(clk),
    .rst(rst),
    .stall(stall),
    .flushEntry(flushEntry),
    .dispWrite(dispWrite),
    .dispPtr(dispPtr),
    .issueValid(issueValid),
    .issuePtr0(issuePtr0),
    .issuePtr1(issuePtr1),
    .issuePtr2(issuePtr2),
    .issuePtr3(issuePtr3),
    .notIssued(notIssued)
);

// ==== schedulerTop.sv ====
/*
 * Scheduler top
 * Dispatch, issue queue, wakeup and select stages of the integer scheduler.
 */
`timescale 1ns/1ps

module schedulerTop (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            write,
    input  logic [schedPkg::ENTRY_BITS-1:0] writePtr,
    input  schedPkg::opTypeT                opType,
    input  logic                            subType,
    input  logic                            srcValidA,
    input  logic [schedPkg::TAG_BITS-1:0]   srcTagA,
    input  logic                            srcValidB,
    input  logic [schedPkg::TAG_BITS-1:0]   srcTagB,
    input  logic                            dstValid,
    input  logic [schedPkg::TAG_BITS-1:0]   dstTag,
    input  logic                            stall,
    input  logic [schedPkg::ENTRY_NUM-1:0]  flushEntry,
    output logic [schedPkg::PIPE_NUM-1:0]   issueValid,
    output logic [schedPkg::ENTRY_BITS-1:0] issuePtr0,
    output logic [schedPkg::ENTRY_BITS-1:0] issuePtr1,
    output logic [schedPkg::ENTRY_BITS-1:0] issuePtr2,
    output logic [schedPkg::ENTRY_BITS-1:0] issuePtr3,
    output logic [schedPkg::ENTRY_NUM-1:0]  notIssued
);

    logic dispWrite;
    logic [schedPkg::ENTRY_BITS-1:0] dispPtr;
    logic isInt;
    logic isComplex;
    logic isDiv;
    logic isLoad;
    logic isStore;
    logic dSrcValidA;
    logic [schedPkg::TAG_BITS-1:0] dSrcTagA;
    logic dSrcValidB;
    logic [schedPkg::TAG_BITS-1:0] dSrcTagB;
    logic dDstValid;
    logic [schedPkg::TAG_BITS-1:0] dDstTag;
    logic [schedPkg::ENTRY_NUM-1:0] entryReady;
    logic [schedPkg::ENTRY_NUM-1:0] intReq;
    logic [schedPkg::ENTRY_NUM-1:0] complexReq;
    logic [schedPkg::ENTRY_NUM-1:0] loadReq;
    logic [schedPkg::ENTRY_NUM-1:0] storeReq;
    logic [schedPkg::ENTRY_NUM-1:0] grantVector;
    logic [schedPkg::PIPE_NUM-1:0] bcastValid;
    logic [schedPkg::PIPE_NUM-1:0][schedPkg::TAG_BITS-1:0] bcastTag;
    logic divFree;

    dispatchDecode dispatch (
        .clk, .rst, .write, .writePtr, .opType, .subType,
        .srcValidA, .srcTagA, .srcValidB, .srcTagB, .dstValid, .dstTag,
        .dispWrite, .dispPtr, .isInt, .isComplex, .isDiv, .isLoad, .isStore,
        .dSrcValidA, .dSrcTagA, .dSrcValidB, .dSrcTagB, .dDstValid, .dDstTag
    );

    issueQueue queue (
        .clk, .rst, .dispWrite, .dispPtr,
        .isInt, .isComplex, .isDiv, .isLoad, .isStore,
        .entryReady, .divFree, .grantVector, .flushEntry,
        .notIssued, .intReq, .complexReq, .loadReq, .storeReq
    );

    wakeupLogic wakeup (
        .clk, .rst, .dispWrite, .dispPtr,
        .dSrcValidA, .dSrcTagA, .dSrcValidB, .dSrcTagB, .dDstValid, .dDstTag,
        .bcastValid, .bcastTag, .entryReady
    );

    selectIssue select (
        .clk, .rst, .stall, .intReq, .complexReq, .loadReq, .storeReq,
        .dispWrite, .dispPtr, .isDiv, .dDstValid, .dDstTag,
        .grantVector, .issueValid, .issuePtr0, .issuePtr1, .issuePtr2, .issuePtr3,
        .bcastValid, .bcastTag, .divFree
    );

endmodule

// ==== selectIssue.sv ====
/*
 * Select and issue
 * Grants the lowest ready entry per pipe, registers the issue outputs
 * with the destination tag broadcasts, and tracks divider occupancy.
 */
`timescale 1ns/1ps

module selectIssue (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            stall,
    input  logic [schedPkg::ENTRY_NUM-1:0]                  intReq,
    input  logic [schedPkg::ENTRY_NUM-1:0]                  complexReq,
    input  logic [schedPkg::ENTRY_NUM-1:0]                  loadReq,
    input  logic [schedPkg::ENTRY_NUM-1:0]                  storeReq,
    input  logic                                            dispWrite,
    input  logic [schedPkg::ENTRY_BITS-1:0]                 dispPtr,
    input  logic                                            isDiv,
    input  logic                                            dDstValid,
    input  logic [schedPkg::TAG_BITS-1:0]                   dDstTag,
    output logic [schedPkg::ENTRY_NUM-1:0]                  grantVector,
    output logic [schedPkg::PIPE_NUM-1:0]                   issueValid,
    output logic [schedPkg::ENTRY_BITS-1:0]                 issuePtr0,
    output logic [schedPkg::ENTRY_BITS-1:0]                 issuePtr1,
    output logic [schedPkg::ENTRY_BITS-1:0]                 issuePtr2,
    output logic [schedPkg::ENTRY_BITS-1:0]                 issuePtr3,
    output logic [schedPkg::PIPE_NUM-1:0]                   bcastValid,
    output logic [schedPkg::PIPE_NUM-1:0][schedPkg::TAG_BITS-1:0] bcastTag,
    output logic                                            divFree
);

    logic [schedPkg::PIPE_NUM-1:0][schedPkg::ENTRY_NUM-1:0] req;
    logic [schedPkg::PIPE_NUM-1:0][schedPkg::ENTRY_NUM-1:0] grant;
    logic [schedPkg::PIPE_NUM-1:0][schedPkg::ENTRY_BITS-1:0] grantPtr;
    logic [schedPkg::PIPE_NUM-1:0][schedPkg::ENTRY_BITS-1:0] issuePtrQ;
    logic [schedPkg::ENTRY_NUM-1:0] dstValidMem;
    logic [schedPkg::ENTRY_NUM-1:0] isDivMem;
    logic [schedPkg::TAG_BITS-1:0] dstTagMem [schedPkg::ENTRY_NUM];
    logic [schedPkg::DIV_CNT_BITS-1:0] divCnt;
    logic divIssue;

    always_comb begin
        req[schedPkg::PIPE_INT] = intReq;
        req[schedPkg::PIPE_COMPLEX] = complexReq;
        req[schedPkg::PIPE_LOAD] = loadReq;
        req[schedPkg::PIPE_STORE] = storeReq;
        grantVector = '0;
        for (int p = 0; p < schedPkg::PIPE_NUM; p++) begin
            grant[p] = '0;
            grantPtr[p] = '0;
            // Scan downward so the lowest requesting entry wins
            for (int i = schedPkg::ENTRY_NUM - 1; i >= 0; i--) begin
                if (req[p][i] && !stall) begin
                    grant[p] = '0;
                    grant[p][i] = 1'b1;
                    grantPtr[p] = schedPkg::ENTRY_BITS'(i);
                end
            end
            grantVector |= grant[p];
        end
        divIssue = |(grant[schedPkg::PIPE_COMPLEX] & isDivMem);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            issueValid <= '0;
            bcastValid <= '0;
            divCnt <= '0;
        end else begin
            for (int p = 0; p < schedPkg::PIPE_NUM; p++) begin
                issueValid[p] <= |grant[p];
                bcastValid[p] <= (|grant[p]) && dstValidMem[grantPtr[p]];
            end
            if (divIssue) begin
                divCnt <= schedPkg::DIV_CNT_BITS'(schedPkg::DIV_LATENCY);
            end else if (divCnt != '0) begin
                divCnt <= divCnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < schedPkg::PIPE_NUM; p++) begin
            issuePtrQ[p] <= grantPtr[p];
            bcastTag[p] <= dstTagMem[grantPtr[p]];
        end
        // Destination info per entry, looked up again at grant
        if (dispWrite) begin
            dstValidMem[dispPtr] <= dDstValid;
            dstTagMem[dispPtr] <= dDstTag;
            isDivMem[dispPtr] <= isDiv;
        end
    end

    assign issuePtr0 = issuePtrQ[schedPkg::PIPE_INT];
    assign issuePtr1 = issuePtrQ[schedPkg::PIPE_COMPLEX];
    assign issuePtr2 = issuePtrQ[schedPkg::PIPE_LOAD];
    assign issuePtr3 = issuePtrQ[schedPkg::PIPE_STORE];
    assign divFree = (divCnt == '0);

endmodule

// ==== wakeupLogic.sv ====
/*
 * Wakeup logic
 * Tracks physical register readiness and per-entry source readiness,
 * both updated by the destination tag broadcasts from issue.
 */
`timescale 1ns/1ps

module wakeupLogic (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            dispWrite,
    input  logic [schedPkg::ENTRY_BITS-1:0]                 dispPtr,
    input  logic                                            dSrcValidA,
    input  logic [schedPkg::TAG_BITS-1:0]                   dSrcTagA,
    input  logic                                            dSrcValidB,
    input  logic [schedPkg::TAG_BITS-1:0]                   dSrcTagB,
    input  logic                                            dDstValid,
    input  logic [schedPkg::TAG_BITS-1:0]                   dDstTag,
    input  logic [schedPkg::PIPE_NUM-1:0]                   bcastValid,
    input  logic [schedPkg::PIPE_NUM-1:0][schedPkg::TAG_BITS-1:0] bcastTag,
    output logic [schedPkg::ENTRY_NUM-1:0]                  entryReady
);

    logic [schedPkg::PHY_REG_NUM-1:0] regReady;
    logic [schedPkg::TAG_BITS-1:0] srcTagA [schedPkg::ENTRY_NUM];
    logic [schedPkg::TAG_BITS-1:0] srcTagB [schedPkg::ENTRY_NUM];
    logic [schedPkg::ENTRY_NUM-1:0] readyA;
    logic [schedPkg::ENTRY_NUM-1:0] readyB;

    function automatic logic bcastHit(input logic [schedPkg::TAG_BITS-1:0] tag);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < schedPkg::PIPE_NUM; p++) begin
            hit |= bcastValid[p] && (bcastTag[p] == tag);
        end
        return hit;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            regReady <= '1;
        end else begin
            for (int p = 0; p < schedPkg::PIPE_NUM; p++) begin
                if (bcastValid[p]) begin
                    regReady[bcastTag[p]] <= 1'b1;
                end
            end
            // New producer allocated
            if (dispWrite && dDstValid) begin
                regReady[dDstTag] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < schedPkg::ENTRY_NUM; i++) begin
            if (bcastHit(srcTagA[i])) readyA[i] <= 1'b1;
            if (bcastHit(srcTagB[i])) readyB[i] <= 1'b1;
        end
        // Bypass the broadcast that lands in the dispatch cycle
        if (dispWrite) begin
            srcTagA[dispPtr] <= dSrcTagA;
            srcTagB[dispPtr] <= dSrcTagB;
            readyA[dispPtr] <= !dSrcValidA || regReady[dSrcTagA] || bcastHit(dSrcTagA);
            readyB[dispPtr] <= !dSrcValidB || regReady[dSrcTagB] || bcastHit(dSrcTagB);
        end
    end

    assign entryReady = readyA & readyB;

endmodule

// ==== issueQueue.sv ====
/*
 * Issue queue
 * Holds a not-issued flag and pipe class flags per entry and raises
 * per-pipe issue requests for ready entries, holding back divs while
 * the divider is busy.
 */
`timescale 1ns/1ps

module issueQueue (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            dispWrite,
    input  logic [schedPkg::ENTRY_BITS-1:0] dispPtr,
    input  logic                            isInt,
    input  logic                            isComplex,
    input  logic                            isDiv,
    input  logic                            isLoad,
    input  logic                            isStore,
    input  logic [schedPkg::ENTRY_NUM-1:0]  entryReady,
    input  logic                            divFree,
    input  logic [schedPkg::ENTRY_NUM-1:0]  grantVector,
    input  logic [schedPkg::ENTRY_NUM-1:0]  flushEntry,
    output logic [schedPkg::ENTRY_NUM-1:0]  notIssued,
    output logic [schedPkg::ENTRY_NUM-1:0]  intReq,
    output logic [schedPkg::ENTRY_NUM-1:0]  complexReq,
    output logic [schedPkg::ENTRY_NUM-1:0]  loadReq,
    output logic [schedPkg::ENTRY_NUM-1:0]  storeReq
);

    logic [schedPkg::ENTRY_NUM-1:0] entryInt;
    logic [schedPkg::ENTRY_NUM-1:0] entryComplex;
    logic [schedPkg::ENTRY_NUM-1:0] entryDiv;
    logic [schedPkg::ENTRY_NUM-1:0] entryLoad;
    logic [schedPkg::ENTRY_NUM-1:0] entryStore;
    logic [schedPkg::ENTRY_NUM-1:0] canIssue;

    // notIssued doubles as the entry valid bit
    always_ff @(posedge clk) begin
        if (rst) begin
            notIssued <= '0;
        end else begin
            if (dispWrite) begin
                notIssued[dispPtr] <= 1'b1;
            end
            // Grant and flush win over a dispatch into the same entry
            for (int i = 0; i < schedPkg::ENTRY_NUM; i++) begin
                if (grantVector[i] || flushEntry[i]) begin
                    notIssued[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispWrite) begin
            entryInt[dispPtr] <= isInt;
            entryComplex[dispPtr] <= isComplex;
            entryDiv[dispPtr] <= isDiv;
            entryLoad[dispPtr] <= isLoad;
            entryStore[dispPtr] <= isStore;
        end
    end

    always_comb begin
        for (int i = 0; i < schedPkg::ENTRY_NUM; i++) begin
            // An entry being flushed this cycle must not be selected
            canIssue[i] = notIssued[i] && !flushEntry[i] && entryReady[i];
            intReq[i] = canIssue[i] && entryInt[i];
            complexReq[i] = canIssue[i] && entryComplex[i] && (!entryDiv[i] || divFree);
            loadReq[i] = canIssue[i] && entryLoad[i];
            storeReq[i] = canIssue[i] && entryStore[i];
        end
    end

endmodule

// ==== dispatchDecode.sv ====
/*
 * Dispatch stage
 * Registers the incoming op and decodes its type into one pipe class
 * plus the div flag, alongside the source and destination tag fields.
 */
`timescale 1ns/1ps

module dispatchDecode (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            write,
    input  logic [schedPkg::ENTRY_BITS-1:0] writePtr,
    input  schedPkg::opTypeT                opType,
    input  logic                            subType,
    input  logic                            srcValidA,
    input  logic [schedPkg::TAG_BITS-1:0]   srcTagA,
    input  logic                            srcValidB,
    input  logic [schedPkg::TAG_BITS-1:0]   srcTagB,
    input  logic                            dstValid,
    input  logic [schedPkg::TAG_BITS-1:0]   dstTag,
    output logic                            dispWrite,
    output logic [schedPkg::ENTRY_BITS-1:0] dispPtr,
    output logic                            isInt,
    output logic                            isComplex,
    output logic                            isDiv,
    output logic                            isLoad,
    output logic                            isStore,
    output logic                            dSrcValidA,
    output logic [schedPkg::TAG_BITS-1:0]   dSrcTagA,
    output logic                            dSrcValidB,
    output logic [schedPkg::TAG_BITS-1:0]   dSrcTagB,
    output logic                            dDstValid,
    output logic [schedPkg::TAG_BITS-1:0]   dDstTag
);

    always_ff @(posedge clk) begin
        if (rst) begin
            dispWrite <= 1'b0;
        end else begin
            dispWrite <= write;
        end
    end

    always_ff @(posedge clk) begin
        dispPtr <= writePtr;
        isComplex <= (opType == schedPkg::OP_COMPLEX);
        isDiv <= (opType == schedPkg::OP_COMPLEX) && subType;
        isLoad <= (opType == schedPkg::OP_MEM) && !subType;
        isStore <= (opType == schedPkg::OP_MEM) && subType;
        // Unused encoding falls back to the integer pipe
        isInt <= (opType != schedPkg::OP_COMPLEX) && (opType != schedPkg::OP_MEM);
        dSrcValidA <= srcValidA;
        dSrcTagA <= srcTagA;
        dSrcValidB <= srcValidB;
        dSrcTagB <= srcTagB;
        dDstValid <= dstValid;
        dDstTag <= dstTag;
    end

endmodule

// ==== schedPkg.sv ====
/*
 * Scheduler constants
 * Issue queue geometry, physical register tags, pipe indices, divider
 * latency and the op type encoding shared by all scheduler stages.
 */
package schedPkg;

    // Issue queue
    localparam int ENTRY_NUM = 8;
    localparam int ENTRY_BITS = 3;

    // Physical register file
    localparam int PHY_REG_NUM = 32;
    localparam int TAG_BITS = 5;

    // Issue pipes, one grant per pipe per cycle
    localparam int PIPE_NUM = 4;
    localparam int PIPE_INT = 0;
    localparam int PIPE_COMPLEX = 1;
    localparam int PIPE_LOAD = 2;
    localparam int PIPE_STORE = 3;

    // Divider stays busy this many cycles after a div issues
    localparam int DIV_LATENCY = 6;
    localparam int DIV_CNT_BITS = $clog2(DIV_LATENCY + 1);

    // subType qualifies the op type:
    //   OP_COMPLEX with subType set is a div
    //   OP_MEM with subType set is a store, otherwise a load
    //   OP_INT ignores subType
    typedef enum logic [1:0] {
        OP_INT,
        OP_COMPLEX,
        OP_MEM
    } opTypeT;

endpackage
